//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := ulpiLinkTb
FILELIST  := all.f
PASS_MSG  := test passed
OBJ_DIR   := obj_dir

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
hw/ulpiPkg.sv
hw/regWriteFifo.sv
hw/phyInitSequencer.sv
hw/ulpiRegWrite.sv
hw/ulpiLinkTop.sv
verification/ulpiPhyModel.sv
verification/ulpiLinkTb.sv

//--- hw/phyInitSequencer.sv
`timescale 1ns/10ps

module phyInitSequencer (
    input  logic               clk_ULPI,
    input  logic               rst,
    // Host side
    input  logic               hostWrite,
    input  ulpiPkg::regWriteT  hostReq,
    output logic               hostReady,
    // Queue side
    input  logic               full,
    output logic               push,
    output ulpiPkg::regWriteT  pushReq
);

    // Position in the init table
    logic [ulpiPkg::INIT_IDX_W-1:0] initIdx;
    // Whole table already queued
    logic initDone;

    assign initDone = (initIdx == ulpiPkg::INIT_IDX_W'(ulpiPkg::INIT_COUNT));

    // Host may strobe only once init is out and there is room
    assign hostReady = initDone && !full;

    // Init phase pushes every cycle with room
    // Host phase forwards accepted strobes only
    always_comb begin
        if (initDone) begin
            push    = hostWrite && hostReady;
            pushReq = hostReq;
        end else begin
            push    = !full;
            pushReq = ulpiPkg::PHY_INIT_TABLE[initIdx];
        end
    end

    // Table walk
    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            initIdx <= '0;
        end else if (!initDone && !full) begin
            // Entry went into the queue this cycle
            initIdx <= initIdx + ulpiPkg::INIT_IDX_W'(1);
        end
    end

    // Queue never sees a push it cannot take
    pushOnlyWithRoom: assert property (
        @(posedge clk_ULPI) disable iff (!rst)
        push |-> !full
    );

endmodule

//--- hw/regWriteFifo.sv
`timescale 1ns/10ps

module regWriteFifo #(
    parameter type payloadT = ulpiPkg::regWriteT
) (
    input  logic    clk_ULPI,
    input  logic    rst,
    // Write side
    input  logic    push,
    input  payloadT pushData,
    output logic    full,
    // Read side, head shown ahead of the pop
    input  logic    pop,
    output payloadT headData,
    output logic    empty
);

    // Storage
    payloadT mem [ulpiPkg::FIFO_DEPTH];

    // Pointers and fill level
    logic [ulpiPkg::FIFO_PTR_W-1:0] wrPtr;
    logic [ulpiPkg::FIFO_PTR_W-1:0] rdPtr;
    logic [ulpiPkg::FIFO_CNT_W-1:0] count;

    // Effective operations
    logic doPush;
    logic doPop;

    assign full  = (count == ulpiPkg::FIFO_CNT_W'(ulpiPkg::FIFO_DEPTH));
    assign empty = (count == '0);

    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    // First word falls through
    assign headData = mem[rdPtr];

    // Entry write
    always_ff @(posedge clk_ULPI) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    // Pointer and count update, wrap at depth
    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == ulpiPkg::FIFO_PTR_W'(ulpiPkg::FIFO_DEPTH - 1)) ?
                         '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == ulpiPkg::FIFO_PTR_W'(ulpiPkg::FIFO_DEPTH - 1)) ?
                         '0 : rdPtr + 1'b1;
            end
            // Simultaneous push and pop leave the level alone
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Reader must wait for data
    noPopWhenEmpty: assert property (
        @(posedge clk_ULPI) disable iff (!rst)
        pop |-> !empty
    );

    // Writer must respect full
    noPushWhenFull: assert property (
        @(posedge clk_ULPI) disable iff (!rst)
        push |-> !full
    );

endmodule

//--- hw/ulpiLinkTop.sv
`timescale 1ns/10ps

module ulpiLinkTop (
    input  logic               clk_ULPI,
    input  logic               rst,
    // Host side
    input  logic               hostWrite,
    input  ulpiPkg::regWriteT  hostReq,
    output logic               hostReady,
    // ULPI pins
    input  logic               dir,
    input  logic               nxt,
    output ulpiPkg::ulpiTxT    ulpiTx,
    output logic               busy
);

    // Sequencer to queue
    logic              push;
    ulpiPkg::regWriteT pushReq;
    logic              full;

    // Queue to writer
    logic              pop;
    ulpiPkg::regWriteT headReq;
    logic              empty;

    // Init table first, host writes after
    phyInitSequencer phyInitSequencer_inst (
        .clk_ULPI  (clk_ULPI),
        .rst       (rst),
        .hostWrite (hostWrite),
        .hostReq   (hostReq),
        .hostReady (hostReady),
        .full      (full),
        .push      (push),
        .pushReq   (pushReq)
    );

    // Pending register writes
    regWriteFifo #(
        .payloadT (ulpiPkg::regWriteT)
    ) regWriteFifo_inst (
        .clk_ULPI (clk_ULPI),
        .rst      (rst),
        .push     (push),
        .pushData (pushReq),
        .full     (full),
        .pop      (pop),
        .headData (headReq),
        .empty    (empty)
    );

    // One ULPI transaction per queued write
    ulpiRegWrite ulpiRegWrite_inst (
        .clk_ULPI (clk_ULPI),
        .rst      (rst),
        .empty    (empty),
        .headReq  (headReq),
        .pop      (pop),
        .dir      (dir),
        .nxt      (nxt),
        .ulpiTx   (ulpiTx),
        .busy     (busy)
    );

endmodule

//--- hw/ulpiPkg.sv
package ulpiPkg;

    // Immediate register write command, bits [7:6] of the TXCMD byte
    localparam logic [1:0] ULPI_CMD_REGWRITE = 2'b10;

    // One PHY register write
    typedef struct packed {
        // PHY register address
        logic [5:0] addr;
        // Data byte to store
        logic [7:0] value;
    } regWriteT;

    // Link-to-PHY side of the ULPI bus
    typedef struct packed {
        logic [7:0] data;
        logic       stp;
    } ulpiTxT;

    // Queue sizing
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    // Count has to reach FIFO_DEPTH itself
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // Init table sizing
    localparam int INIT_COUNT = 3;
    localparam int INIT_IDX_W = $clog2(INIT_COUNT + 1);

    // PHY configuration written once after reset, in order
    localparam regWriteT PHY_INIT_TABLE [INIT_COUNT] = '{
        // Function control
        // HS transceiver, non-driving opmode, SuspendM high
        '{addr: 6'h04, value: 8'h48},
        // OTG control
        // Pulldowns and VBUS drive off
        '{addr: 6'h0A, value: 8'h00},
        // Interface control
        // Plain 8-bit SDR interface
        '{addr: 6'h07, value: 8'h00}
    };

endpackage

//--- hw/ulpiRegWrite.sv
`timescale 1ns/10ps

module ulpiRegWrite (
    input  logic               clk_ULPI,
    input  logic               rst,
    // Queue side
    input  logic               empty,
    input  ulpiPkg::regWriteT  headReq,
    output logic               pop,
    // ULPI side
    input  logic               dir,
    input  logic               nxt,
    output ulpiPkg::ulpiTxT    ulpiTx,
    output logic               busy
);

    // Register write transaction steps
    typedef enum logic [1:0] {
        stIdle,
        stTxCmd,
        stData,
        stStop
    } stateT;

    stateT state;

    // Data byte held until the PHY takes the TXCMD
    logic [7:0] valueQ;

    // Start only with work queued and the bus ours
    assign pop  = (state == stIdle) && !empty && !dir;
    assign busy = (state != stIdle);

    // Payload capture on pop
    always_ff @(posedge clk_ULPI) begin
        if (pop) begin
            valueQ <= headReq.value;
        end
    end

    // Sequencing and bus outputs, all on the rising edge
    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            state  <= stIdle;
            ulpiTx <= '0;
        end else begin
            // STP follows the stop state by one cycle
            ulpiTx.stp <= (state == stStop);
            case (state)
                stIdle: begin
                    if (pop) begin
                        state       <= stTxCmd;
                        ulpiTx.data <= {ulpiPkg::ULPI_CMD_REGWRITE, headReq.addr};
                    end else begin
                        ulpiTx.data <= '0;
                    end
                end
                stTxCmd: begin
                    // PHY took the command byte
                    if (nxt) begin
                        state       <= stData;
                        ulpiTx.data <= valueQ;
                    end
                end
                stData: begin
                    // PHY took the data byte
                    if (nxt) begin
                        state       <= stStop;
                        ulpiTx.data <= '0;
                    end
                end
                stStop: begin
                    // Back to idle while STP is out
                    state       <= stIdle;
                    ulpiTx.data <= '0;
                end
                default: begin
                    state       <= stIdle;
                    ulpiTx.data <= '0;
                end
            endcase
        end
    end

    // STP is a lone pulse on a quiet data bus
    stpSinglePulse: assert property (
        @(posedge clk_ULPI) disable iff (!rst)
        ulpiTx.stp |-> (ulpiTx.data == '0) ##1 !ulpiTx.stp
    );

endmodule

//--- verification/ulpiLinkTb.sv
`timescale 1ns/10ps

module ulpiLinkTb;

    localparam int WAIT_LIMIT = 300;
    localparam int CHECK_COUNT = 6;
    localparam int STIM_COUNT = 8;

    // One host write plus the idle cycles after it
    typedef struct packed {
        ulpiPkg::regWriteT req;
        logic [3:0]        gap;
    } hostStimT;

    // Zero gaps flood the queue against the slow PHY
    localparam hostStimT STIM_TABLE [STIM_COUNT] = '{
        '{req: '{addr: 6'h16, value: 8'hA5}, gap: 4'd2},
        '{req: '{addr: 6'h16, value: 8'h5A}, gap: 4'd0},
        '{req: '{addr: 6'h16, value: 8'h3C}, gap: 4'd0},
        '{req: '{addr: 6'h0A, value: 8'h06}, gap: 4'd0},
        '{req: '{addr: 6'h04, value: 8'h45}, gap: 4'd0},
        '{req: '{addr: 6'h07, value: 8'h11}, gap: 4'd0},
        '{req: '{addr: 6'h16, value: 8'hC3}, gap: 4'd3},
        '{req: '{addr: 6'h16, value: 8'hFF}, gap: 4'd0}
    };

    logic              clk_ULPI;
    logic              rst;
    logic              hostWrite;
    ulpiPkg::regWriteT hostReq;
    logic              hostReady;
    logic              dir;
    logic              nxt;
    ulpiPkg::ulpiTxT   ulpiTx;
    logic              busy;
    logic              writeDone;
    ulpiPkg::regWriteT doneReq;

    // Expected writes in order, init table first
    ulpiPkg::regWriteT expQ [$];
    int                errs [1:CHECK_COUNT];
    string             checkName [1:CHECK_COUNT];
    int                doneCount = 0;
    int                txCount = 0;
    int                stpCount = 0;
    logic              prevBusy = 1'b0;
    logic              prevDir = 1'b0;
    logic              prevStp = 1'b0;
    logic              readySeen = 1'b0;
    logic              readyDropped = 1'b0;
    logic              dirSeen = 1'b0;
    logic              timedOut = 1'b0;

    ulpiLinkTop ulpiLinkTop_inst (
        .clk_ULPI  (clk_ULPI),
        .rst       (rst),
        .hostWrite (hostWrite),
        .hostReq   (hostReq),
        .hostReady (hostReady),
        .dir       (dir),
        .nxt       (nxt),
        .ulpiTx    (ulpiTx),
        .busy      (busy)
    );

    ulpiPhyModel ulpiPhyModel_inst (
        .clk_ULPI  (clk_ULPI),
        .rst       (rst),
        .ulpiTx    (ulpiTx),
        .dir       (dir),
        .nxt       (nxt),
        .writeDone (writeDone),
        .doneReq   (doneReq)
    );

    initial begin
        clk_ULPI = 1'b0;
        forever #2 clk_ULPI = ~clk_ULPI;
    end

    task automatic reportMismatch(input int checkNo, input string sigName,
                                  input logic [15:0] expVal, input logic [15:0] actVal);
        $display("MISMATCH time %0t %s expected %h actual %h", $time, sigName, expVal, actVal);
        errs[checkNo]++;
    endtask

    task automatic reportError(input int checkNo, input string what);
        $display("ERROR time %0t check %0d: %s", $time, checkNo, what);
        errs[checkNo]++;
    endtask

    task automatic closeCheck(input int checkNo);
        if (errs[checkNo] == 0) begin
            $display("check %0d, %s: ok", checkNo, checkName[checkNo]);
        end else begin
            $display("check %0d, %s: %0d errors", checkNo, checkName[checkNo], errs[checkNo]);
        end
    endtask

    task automatic abortRun(input string why);
        $display("TIMEOUT time %0t: %s", $time, why);
        timedOut = 1'b1;
    endtask

    // Completed writes against the expected list
    always @(posedge clk_ULPI) begin
        if (rst && writeDone) begin
            if (doneCount >= expQ.size()) begin
                reportError(5, "PHY saw more writes than were requested");
            end else if (doneReq != expQ[doneCount]) begin
                reportMismatch((doneCount < ulpiPkg::INIT_COUNT) ? 2 : 5, "doneReq",
                               16'(expQ[doneCount]), 16'(doneReq));
            end
            doneCount++;
        end
    end

    // Bus rules, checked every cycle
    always @(posedge clk_ULPI) begin
        if (rst) begin
            // Writer leaving idle puts out a new TXCMD
            if (busy && !prevBusy) begin
                if (prevDir) begin
                    reportError(6, "writer started a TXCMD while dir was high");
                end
                if (txCount >= expQ.size()) begin
                    reportError(3, "TXCMD beyond the expected writes");
                end else if (ulpiTx.data != {2'b10, expQ[txCount].addr}) begin
                    reportMismatch(3, "ulpiTx.data", 16'({2'b10, expQ[txCount].addr}),
                                   16'(ulpiTx.data));
                end
                txCount++;
            end
            if (ulpiTx.stp) begin
                if (ulpiTx.data != 8'h00) begin
                    reportMismatch(4, "ulpiTx.data", 16'h0000, 16'(ulpiTx.data));
                end
                if (prevStp) begin
                    reportError(4, "stp stayed high for more than one cycle");
                end
                if (!prevBusy || busy) begin
                    reportError(4, "stp rose outside the end of a write");
                end
                stpCount++;
            end
            if (hostReady) begin
                readySeen = 1'b1;
            end else if (readySeen) begin
                readyDropped = 1'b1;
            end
            if (dir) begin
                dirSeen = 1'b1;
            end
        end
        prevBusy = busy;
        prevDir  = dir;
        prevStp  = ulpiTx.stp;
    end

    initial begin
        int waited;
        logic accepted;
        int totalErrs;
        int failing;

        rst       = 1'b0;
        hostWrite = 1'b0;
        hostReq   = '0;
        void'($urandom(32'hf14c));
        checkName[1] = "reset state";
        checkName[2] = "init table order";
        checkName[3] = "TXCMD header";
        checkName[4] = "stp pulse";
        checkName[5] = "host flood";
        checkName[6] = "dir hold";
        for (int t = 1; t <= CHECK_COUNT; t++) begin
            errs[t] = 0;
        end
        for (int i = 0; i < ulpiPkg::INIT_COUNT; i++) begin
            expQ.push_back(ulpiPkg::PHY_INIT_TABLE[i]);
        end
        for (int i = 0; i < STIM_COUNT; i++) begin
            expQ.push_back(STIM_TABLE[i].req);
        end

        begin : stimulus
            repeat (2) @(posedge clk_ULPI);
            rst <= 1'b1;

            // hostReady stays low while the init entries go in, one per cycle
            for (int k = 1; k <= ulpiPkg::INIT_COUNT + 1; k++) begin
                @(posedge clk_ULPI);
                if (k == 1) begin
                    if (ulpiTx.data != 8'h00) begin
                        reportMismatch(1, "ulpiTx.data", 16'h0000, 16'(ulpiTx.data));
                    end
                    if (ulpiTx.stp || busy || hostReady) begin
                        reportError(1, "stp, busy or hostReady high right after reset");
                    end
                end
                if (k <= ulpiPkg::INIT_COUNT && hostReady) begin
                    reportError(2, "hostReady rose before the init table was queued");
                end
                if (k == ulpiPkg::INIT_COUNT + 1 && !hostReady) begin
                    reportError(2, "hostReady still low after the init table was queued");
                end
            end
            closeCheck(1);

            // Completion count polled away from the rising edge
            waited = 0;
            while (doneCount < ulpiPkg::INIT_COUNT && waited < WAIT_LIMIT) begin
                @(negedge clk_ULPI);
                waited++;
            end
            if (doneCount < ulpiPkg::INIT_COUNT) begin
                abortRun("init writes never completed");
                disable stimulus;
            end
            closeCheck(2);
            @(posedge clk_ULPI);

            // Strobe stays up until a cycle with hostReady high takes it
            for (int i = 0; i < STIM_COUNT; i++) begin
                hostReq   <= STIM_TABLE[i].req;
                hostWrite <= 1'b1;
                accepted = 1'b0;
                waited = 0;
                while (!accepted && waited < WAIT_LIMIT) begin
                    @(posedge clk_ULPI);
                    waited++;
                    accepted = hostReady;
                end
                if (!accepted) begin
                    abortRun("host write never accepted");
                    disable stimulus;
                end
                if (STIM_TABLE[i].gap != 0 || i == STIM_COUNT - 1) begin
                    hostWrite <= 1'b0;
                    repeat (STIM_TABLE[i].gap) @(posedge clk_ULPI);
                end
            end

            waited = 0;
            while (doneCount < expQ.size() && waited < WAIT_LIMIT) begin
                @(negedge clk_ULPI);
                waited++;
            end
            if (doneCount < expQ.size()) begin
                abortRun("host writes never all completed");
                disable stimulus;
            end
            // Quiet tail to catch duplicates
            repeat (30) @(posedge clk_ULPI);
            if (doneCount != expQ.size()) begin
                reportError(5, "number of completed writes differs from the requests");
            end
            if (!readyDropped) begin
                reportError(5, "hostReady never dropped under back-to-back strobes");
            end
            closeCheck(5);

            if (txCount != doneCount) begin
                reportError(3, "TXCMD count differs from completed writes");
            end
            closeCheck(3);
            if (stpCount != doneCount) begin
                reportError(4, "stp pulse count differs from completed writes");
            end
            closeCheck(4);
            if (!dirSeen) begin
                reportError(6, "PHY model never raised dir");
            end
            closeCheck(6);
        end

        totalErrs = 0;
        failing = 0;
        for (int t = 1; t <= CHECK_COUNT; t++) begin
            totalErrs += errs[t];
            if (errs[t] != 0) begin
                failing++;
            end
        end
        $display("checks: %0d, failing: %0d, errors: %0d", CHECK_COUNT, failing, totalErrs);
        if (timedOut || totalErrs != 0) begin
            $display("test failed");
        end else begin
            $display("test passed");
        end
        $finish;
    end

endmodule

//--- verification/ulpiPhyModel.sv
`timescale 1ns/10ps

module ulpiPhyModel (
    input  logic               clk_ULPI,
    input  logic               rst,
    // Link side of the bus
    input  ulpiPkg::ulpiTxT    ulpiTx,
    output logic               dir,
    output logic               nxt,
    // Completed writes for the testbench
    output logic               writeDone,
    output ulpiPkg::regWriteT  doneReq
);

    // Where the PHY is within one register write
    typedef enum logic [1:0] {
        phIdle,
        phCmd,
        phData,
        phStop
    } phaseT;

    phaseT       phase;
    logic [5:0]  addrQ;
    logic [7:0]  valueQ;
    // Cycles left before NXT
    int unsigned waitCnt;
    // Cycles left with DIR high
    int unsigned dirCnt;

    always @(posedge clk_ULPI) begin
        if (!rst) begin
            phase     <= phIdle;
            dir       <= 1'b0;
            nxt       <= 1'b0;
            writeDone <= 1'b0;
            doneReq   <= '0;
            addrQ     <= '0;
            valueQ    <= '0;
            waitCnt   <= 0;
            dirCnt    <= 0;
        end else begin
            writeDone <= 1'b0;
            // Turnaround back to the link
            if (dirCnt > 1) begin
                dirCnt <= dirCnt - 1;
            end else if (dirCnt == 1) begin
                dirCnt <= 0;
                dir    <= 1'b0;
            end
            case (phase)
                phIdle: begin
                    // Register write header seen
                    if (ulpiTx.data[7:6] == 2'b10) begin
                        addrQ   <= ulpiTx.data[5:0];
                        waitCnt <= $urandom % 4;
                        phase   <= phCmd;
                    end
                end
                phCmd: begin
                    if (nxt) begin
                        // Link moves to the data byte on this edge
                        nxt     <= 1'b0;
                        waitCnt <= $urandom % 4;
                        phase   <= phData;
                    end else if (waitCnt == 0 && !dir) begin
                        nxt <= 1'b1;
                    end else if (waitCnt != 0) begin
                        waitCnt <= waitCnt - 1;
                    end
                end
                phData: begin
                    if (nxt) begin
                        // Second NXT takes the value
                        valueQ <= ulpiTx.data;
                        nxt    <= 1'b0;
                        phase  <= phStop;
                    end else if (waitCnt == 0 && !dir) begin
                        nxt <= 1'b1;
                    end else if (waitCnt != 0) begin
                        waitCnt <= waitCnt - 1;
                    end
                end
                phStop: begin
                    if (ulpiTx.stp) begin
                        writeDone <= 1'b1;
                        doneReq   <= '{addr: addrQ, value: valueQ};
                        phase     <= phIdle;
                    end else if (!dir && ($urandom % 3 != 0)) begin
                        // Sometimes grab the bus over the STP cycle
                        // Link could otherwise start its next write right there
                        dir    <= 1'b1;
                        dirCnt <= 1 + ($urandom % 3);
                    end
                end
                default: begin
                    phase <= phIdle;
                end
            endcase
        end
    end

endmodule
